//--- common/pio_defines.svh
`ifndef PIO_DEFINES_SVH
`define PIO_DEFINES_SVH

// Number of state machines sharing the instruction memory
`define PIO_NUM_SM 4

// Shared instruction memory, one 16-bit instruction per word
`define PIO_IMEM_DEPTH 32
`define PIO_ADDR_W 5

// Entries in every transmit and receive FIFO
`define PIO_FIFO_DEPTH 4

// Data word carried by the FIFOs and the shift registers
`define PIO_WORD_W 32

// Clock divider width
`define PIO_DIV_W 16

`endif

//--- common/pio_pkg.sv
package pio_pkg;

  typedef enum logic [2:0] {
    OP_JMP  = 3'd0,
    OP_WAIT = 3'd1,
    OP_IN   = 3'd2,
    OP_OUT  = 3'd3,
    OP_PUSH = 3'd4,
    OP_PULL = 3'd5,
    OP_NOP  = 3'd6,
    OP_SET  = 3'd7
  } opcode_e;

  // 16-bit instruction word as stored in the instruction memory
  typedef struct packed {
    opcode_e    op;
    logic [4:0] delay; // Extra ticks after execution
    logic [2:0] sel;   // Condition, source or destination
    logic [4:0] data;  // Address, bit count, pin or immediate
  } instr_t;

  typedef enum logic [2:0] {
    ALWAYS = 3'd0,
    X_ZERO = 3'd1,
    X_DEC  = 3'd2, // Jump if X nonzero, then decrement
    Y_ZERO = 3'd3,
    Y_DEC  = 3'd4,
    PIN    = 3'd5
  } jmp_cond_e;

  typedef enum logic [2:0] {
    PINS    = 3'd0,
    X       = 3'd1,
    Y       = 3'd2,
    NULL    = 3'd3,
    PINDIRS = 3'd4
  } src_dst_e;

  typedef enum logic [1:0] {
    ST_OFF,
    ST_RUN,
    ST_DELAY,
    ST_STALL
  } sm_state_e;

  typedef enum logic [3:0] {
    ACT_NOP      = 4'd0,
    ACT_INSTR    = 4'd1,
    ACT_WRAP     = 4'd2,
    ACT_READ_RX  = 4'd3,
    ACT_WRITE_TX = 4'd4,
    ACT_PINS     = 4'd5,
    ACT_ENABLE   = 4'd6,
    ACT_DIV      = 4'd7,
    ACT_JMP_PIN  = 4'd8,
    ACT_EXEC     = 4'd9,
    ACT_STATUS   = 4'd10
  } action_e;

endpackage

//--- common/pio_fifo_if.sv
`timescale 1ns/100ps
`include "pio_defines.svh"

interface pio_fifo_if;

  logic                   push;
  logic                   pull;
  logic [`PIO_WORD_W-1:0] wdata;
  logic [`PIO_WORD_W-1:0] rdata; // Head entry, valid while not empty
  logic                   empty;
  logic                   full;

  modport writer (
    output push, wdata,
    input  full
  );

  modport reader (
    output pull,
    input  rdata, empty
  );

  modport fifo (
    input  push, pull, wdata,
    output rdata, empty, full
  );

endinterface

//--- hw/pio_fifo.sv
`timescale 1ns/100ps
`include "pio_defines.svh"

module pio_fifo (
  input  logic       clk,
  input  logic       reset,
  pio_fifo_if.fifo   port
);

  localparam int PTR_W = $clog2(`PIO_FIFO_DEPTH);
  localparam int CNT_W = $clog2(`PIO_FIFO_DEPTH + 1);

  logic [`PIO_WORD_W-1:0] mem [`PIO_FIFO_DEPTH];
  logic [PTR_W-1:0]       wptr;
  logic [PTR_W-1:0]       rptr;
  logic [CNT_W-1:0]       count;
  logic                   do_push;
  logic                   do_pull;

  assign do_push = port.push && !port.full;  // Push while full is dropped
  assign do_pull = port.pull && !port.empty;

  assign port.empty = (count == '0);
  assign port.full  = (count == CNT_W'(`PIO_FIFO_DEPTH));
  assign port.rdata = mem[rptr];             // Show-ahead head

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wptr] <= port.wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      if (do_push) wptr <= wptr + 1'b1;      // Depth is a power of two
      if (do_pull) rptr <= rptr + 1'b1;
      count <= count + CNT_W'(do_push) - CNT_W'(do_pull);
    end
  end

endmodule

//--- hw/machine/pio_clock_div.sv
`timescale 1ns/100ps
`include "pio_defines.svh"

module pio_clock_div (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  run,
  input  logic [`PIO_DIV_W-1:0] div,
  output logic                  tick
);

  logic [`PIO_DIV_W-1:0] count;

  // Count of 0 or 1 ticks every cycle
  assign tick = run && (count <= `PIO_DIV_W'(1));

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (!run) begin
      count <= div;                // Restart from the reload value
    end else if (tick) begin
      count <= div;
    end else begin
      count <= count - 1'b1;
    end
  end

endmodule

//--- hw/machine/pio_machine.sv
`timescale 1ns/100ps
`include "pio_defines.svh"

module pio_machine (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   en,
  input  logic                   tick,
  input  logic [15:0]            instr,
  input  logic                   exec,
  input  logic [15:0]            exec_instr,
  input  logic [`PIO_ADDR_W-1:0] wrap_start,
  input  logic [`PIO_ADDR_W-1:0] wrap_end,
  input  logic                   wrap_load,
  input  logic [20:0]            pin_cfg,
  input  logic [4:0]             jmp_pin,
  input  logic [31:0]            gpio_in,
  output logic [`PIO_ADDR_W-1:0] pc,
  output logic [31:0]            pins,
  output logic [31:0]            dirs,
  pio_fifo_if.reader             tx,
  pio_fifo_if.writer             rx,
  output logic                   busy
);

  pio_pkg::sm_state_e state;
  pio_pkg::instr_t    ir;
  logic [4:0]             dcnt;     // Remaining delay ticks
  logic [`PIO_WORD_W-1:0] x, y, isr, osr;
  logic [`PIO_WORD_W-1:0] x_n, y_n, isr_n, osr_n, pins_n, dirs_n;
  logic [`PIO_ADDR_W-1:0] pc_n;
  logic [5:0]  bit_cnt;
  logic [31:0] cnt_mask, in_src, out_val, set_val, out_grp, set_grp;
  logic        do_exec, stall, jump, fire, push_req, pull_req;

  function automatic logic [31:0] rotl(input logic [31:0] v, input logic [4:0] s);
    logic [63:0] t;
    t = {v, v} << s;
    return t[63:32];
  endfunction

  function automatic logic [31:0] rotr(input logic [31:0] v, input logic [4:0] s);
    logic [63:0] t;
    t = {v, v} >> s;
    return t[31:0];
  endfunction

  function automatic logic [31:0] low_mask(input logic [5:0] n);
    logic [32:0] m;
    m = (33'd1 << n) - 33'd1;
    return m[31:0];
  endfunction

  // pin_cfg: out count, out base, set count, set base, in base from bit 0 up
  assign out_grp = rotl(low_mask({3'b0, pin_cfg[2:0]}), pin_cfg[7:3]);
  assign set_grp = rotl(low_mask({3'b0, pin_cfg[10:8]}), pin_cfg[15:11]);

  assign ir       = exec ? pio_pkg::instr_t'(exec_instr) : pio_pkg::instr_t'(instr);
  assign do_exec  = exec || (en && tick && (state == pio_pkg::ST_RUN ||
                                            state == pio_pkg::ST_STALL));
  assign bit_cnt  = (ir.data == 5'd0) ? 6'd32 : {1'b0, ir.data};
  assign cnt_mask = low_mask(bit_cnt);
  assign out_val  = osr & cnt_mask;
  assign set_val  = {27'b0, ir.data};
  assign fire     = do_exec && !stall;
  assign busy     = (state != pio_pkg::ST_OFF); // Divider runs only when on

  assign tx.pull  = fire && pull_req;
  assign rx.push  = fire && push_req;
  assign rx.wdata = isr;

  always_comb begin
    x_n = x;
    y_n = y;
    isr_n = isr;
    osr_n = osr;
    pins_n = pins;
    dirs_n = dirs;
    in_src = '0;
    stall = 1'b0;
    jump = 1'b0;
    push_req = 1'b0;
    pull_req = 1'b0;
    case (ir.op)
      pio_pkg::OP_JMP: begin
        case (pio_pkg::jmp_cond_e'(ir.sel))
          pio_pkg::ALWAYS: jump = 1'b1;
          pio_pkg::X_ZERO: jump = (x == '0);
          pio_pkg::X_DEC: begin
            jump = (x != '0);
            x_n  = x - 1'b1;               // Post-decrement either way
          end
          pio_pkg::Y_ZERO: jump = (y == '0);
          pio_pkg::Y_DEC: begin
            jump = (y != '0);
            y_n  = y - 1'b1;
          end
          pio_pkg::PIN: jump = gpio_in[jmp_pin];
          default: jump = 1'b0;
        endcase
      end
      pio_pkg::OP_WAIT: stall = (gpio_in[ir.data] != ir.sel[2]); // Bit 7 is polarity
      pio_pkg::OP_IN: begin
        case (pio_pkg::src_dst_e'(ir.sel))
          pio_pkg::PINS: in_src = rotr(gpio_in, pin_cfg[20:16]);
          pio_pkg::X:    in_src = x;
          pio_pkg::Y:    in_src = y;
          default:       in_src = '0;
        endcase
        isr_n = (isr << bit_cnt) | (in_src & cnt_mask); // ISR shifts left
      end
      pio_pkg::OP_OUT: begin
        osr_n = osr >> bit_cnt;            // OSR shifts right
        case (pio_pkg::src_dst_e'(ir.sel))
          pio_pkg::PINS:    pins_n = (pins & ~out_grp) | (rotl(out_val, pin_cfg[7:3]) & out_grp);
          pio_pkg::X:       x_n = out_val;
          pio_pkg::Y:       y_n = out_val;
          pio_pkg::PINDIRS: dirs_n = (dirs & ~out_grp) | (rotl(out_val, pin_cfg[7:3]) & out_grp);
          default: ;
        endcase
      end
      pio_pkg::OP_PUSH: begin
        stall    = rx.full;
        push_req = 1'b1;
        isr_n    = '0;
      end
      pio_pkg::OP_PULL: begin
        stall    = tx.empty;
        pull_req = 1'b1;
        osr_n    = tx.rdata;
      end
      pio_pkg::OP_SET: begin
        case (pio_pkg::src_dst_e'(ir.sel))
          pio_pkg::PINS:    pins_n = (pins & ~set_grp) | (rotl(set_val, pin_cfg[15:11]) & set_grp);
          pio_pkg::X:       x_n = set_val;
          pio_pkg::Y:       y_n = set_val;
          pio_pkg::PINDIRS: dirs_n = (dirs & ~set_grp) | (rotl(set_val, pin_cfg[15:11]) & set_grp);
          default: ;
        endcase
      end
      default: ;                           // NOP
    endcase

    if (jump) pc_n = ir.data;
    else if (exec) pc_n = pc;              // Immediate instructions keep the PC
    else if (pc == wrap_end) pc_n = wrap_start;
    else pc_n = pc + 1'b1;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= pio_pkg::ST_OFF;
      pc    <= '0;
      dcnt  <= '0;
      x     <= '0;
      y     <= '0;
      isr   <= '0;
      osr   <= '0;
      pins  <= '0;
      dirs  <= '0;
    end else begin
      if (wrap_load) pc <= wrap_start;
      else if (fire) pc <= pc_n;
      if (fire) begin
        x    <= x_n;
        y    <= y_n;
        isr  <= isr_n;
        osr  <= osr_n;
        pins <= pins_n;
        dirs <= dirs_n;
      end

      if (!en) begin
        state <= pio_pkg::ST_OFF;
      end else if (!exec) begin             // Exec borrows this cycle's slot
        case (state)
          pio_pkg::ST_OFF: state <= pio_pkg::ST_RUN;
          pio_pkg::ST_RUN, pio_pkg::ST_STALL: begin
            if (tick) begin
              if (stall) begin
                state <= pio_pkg::ST_STALL; // Retried on the next tick
              end else if (ir.delay != 5'd0) begin
                state <= pio_pkg::ST_DELAY;
                dcnt  <= ir.delay;
              end else begin
                state <= pio_pkg::ST_RUN;
              end
            end
          end
          pio_pkg::ST_DELAY: begin
            if (tick) begin
              dcnt <= dcnt - 1'b1;
              if (dcnt == 5'd1) state <= pio_pkg::ST_RUN;
            end
          end
          default: state <= pio_pkg::ST_OFF;
        endcase
      end
    end
  end

endmodule

//--- hw/pio.sv
`timescale 1ns/100ps
`include "pio_defines.svh"

module pio (
  input  logic             clk,
  input  logic             reset,
  input  logic [1:0]       mindex,
  input  logic [4:0]       index,
  input  pio_pkg::action_e action,
  input  logic [31:0]      din,
  output logic [31:0]      dout,
  input  logic [31:0]      gpio_in,
  output logic [31:0]      gpio_out,
  output logic [31:0]      gpio_dir
);

  logic [15:0] imem [`PIO_IMEM_DEPTH];     // Shared by all machines

  logic [`PIO_NUM_SM-1:0] en;
  logic [`PIO_NUM_SM-1:0] wrap_load;
  logic [`PIO_NUM_SM-1:0] exec;
  logic [15:0]            exec_instr;
  logic [`PIO_ADDR_W-1:0] wrap_start [`PIO_NUM_SM];
  logic [`PIO_ADDR_W-1:0] wrap_end   [`PIO_NUM_SM];
  logic [20:0]            pin_cfg    [`PIO_NUM_SM];
  logic [`PIO_DIV_W-1:0]  div        [`PIO_NUM_SM];
  logic [4:0]             jmp_pin    [`PIO_NUM_SM];

  logic [`PIO_ADDR_W-1:0] pc      [`PIO_NUM_SM];
  logic [31:0]            sm_pins [`PIO_NUM_SM];
  logic [31:0]            sm_dirs [`PIO_NUM_SM];
  logic [`PIO_WORD_W-1:0] rx_rdata [`PIO_NUM_SM];
  logic [`PIO_NUM_SM-1:0] rx_empty, rx_full, tx_empty, tx_full;
  logic [`PIO_NUM_SM-1:0] tick, busy;
  logic [31:0]            status;

  pio_fifo_if tx_if [`PIO_NUM_SM] ();
  pio_fifo_if rx_if [`PIO_NUM_SM] ();

  // Receive empty, receive full, then transmit empty and full above
  assign status = {16'b0, tx_full, tx_empty, rx_full, rx_empty};

  always_ff @(posedge clk) begin
    if (action == pio_pkg::ACT_INSTR) begin
      imem[index] <= din[15:0];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      en        <= '0;
      wrap_load <= '0;
      exec      <= '0;
      dout      <= '0;
      for (int i = 0; i < `PIO_NUM_SM; i++) begin
        wrap_start[i] <= '0;
        wrap_end[i]   <= '0;
        pin_cfg[i]    <= '0;
        div[i]        <= '0;
        jmp_pin[i]    <= '0;
      end
    end else begin
      wrap_load <= '0;                     // Single-cycle strobes
      exec      <= '0;
      case (action)
        pio_pkg::ACT_WRAP: begin
          wrap_start[mindex] <= din[4:0];
          wrap_end[mindex]   <= din[9:5];
          wrap_load[mindex]  <= 1'b1;      // PC follows once the window is set
        end
        pio_pkg::ACT_READ_RX: dout <= rx_rdata[mindex];
        pio_pkg::ACT_PINS:    pin_cfg[mindex] <= din[20:0];
        pio_pkg::ACT_ENABLE:  en <= din[`PIO_NUM_SM-1:0];
        pio_pkg::ACT_DIV:     div[mindex] <= din[`PIO_DIV_W-1:0];
        pio_pkg::ACT_JMP_PIN: jmp_pin[mindex] <= din[4:0];
        pio_pkg::ACT_EXEC: begin
          exec[mindex] <= 1'b1;
          exec_instr   <= din[15:0];
        end
        pio_pkg::ACT_STATUS:  dout <= status;
        default: ;
      endcase
    end
  end

  for (genvar j = 0; j < `PIO_NUM_SM; j++) begin : g_sm
    assign tx_if[j].push  = (action == pio_pkg::ACT_WRITE_TX) && (mindex == 2'(j));
    assign tx_if[j].wdata = din;
    assign rx_if[j].pull  = (action == pio_pkg::ACT_READ_RX) && (mindex == 2'(j));

    assign rx_rdata[j] = rx_if[j].rdata;
    assign rx_empty[j] = rx_if[j].empty;
    assign rx_full[j]  = rx_if[j].full;
    assign tx_empty[j] = tx_if[j].empty;
    assign tx_full[j]  = tx_if[j].full;

    pio_fifo tx_fifo_i (
      .clk   (clk),
      .reset (reset),
      .port  (tx_if[j])
    );

    pio_fifo rx_fifo_i (
      .clk   (clk),
      .reset (reset),
      .port  (rx_if[j])
    );

    pio_clock_div clock_div_i (
      .clk   (clk),
      .reset (reset),
      .run   (busy[j]),
      .div   (div[j]),
      .tick  (tick[j])
    );

    pio_machine machine_i (
      .clk        (clk),
      .reset      (reset),
      .en         (en[j]),
      .tick       (tick[j]),
      .instr      (imem[pc[j]]),
      .exec       (exec[j]),
      .exec_instr (exec_instr),
      .wrap_start (wrap_start[j]),
      .wrap_end   (wrap_end[j]),
      .wrap_load  (wrap_load[j]),
      .pin_cfg    (pin_cfg[j]),
      .jmp_pin    (jmp_pin[j]),
      .gpio_in    (gpio_in),
      .pc         (pc[j]),
      .pins       (sm_pins[j]),
      .dirs       (sm_dirs[j]),
      .tx         (tx_if[j]),
      .rx         (rx_if[j]),
      .busy       (busy[j])
    );
  end

  always_comb begin
    gpio_out = '0;
    gpio_dir = '0;
    for (int i = 0; i < `PIO_NUM_SM; i++) begin
      gpio_out |= sm_pins[i];              // Machines share the pins by OR
      gpio_dir |= sm_dirs[i];
    end
  end

endmodule

//--- sim/pio_assertions.sv
`timescale 1ns/100ps
`include "pio_defines.svh"

module pio_assertions (
  input logic                                clk,
  input logic                                reset,
  input logic                                full,
  input logic                                empty,
  input logic                                push,
  input logic [$clog2(`PIO_FIFO_DEPTH)-1:0]  wptr,
  input pio_pkg::sm_state_e                  state,
  input logic                                en,
  input logic                                exec
);

  // Count cannot be zero and at depth together
  full_not_empty: assert property (@(posedge clk) disable iff (reset)
    !(full && empty))
    else $error("FIFO reports full and empty in the same cycle");

  // Dropped push keeps the write pointer
  no_push_when_full: assert property (@(posedge clk) disable iff (reset)
    (push && full) |=> (wptr == $past(wptr)))
    else $error("FIFO accepted a push while full");

  stay_off: assert property (@(posedge clk) disable iff (reset)
    (state == pio_pkg::ST_OFF && !en && !exec) |=> (state == pio_pkg::ST_OFF))
    else $error("Machine left the off state while disabled and without exec");

endmodule

//--- sim/pio_tb.sv
`timescale 1ns/100ps
`include "pio_defines.svh"

module pio_tb;

  localparam int CHK_NONE = 0;
  localparam int CHK_DOUT = 1; // Compare dout after the command
  localparam int CHK_RX   = 2; // Poll status, then read the receive head
  localparam int CHK_RXE  = 3; // Receive FIFO of mindex still empty
  localparam int CHK_OUT  = 4;
  localparam int CHK_DIR  = 5;
  localparam int CHK_TXE  = 6; // Wait for transmit FIFO empty, then gpio_out
  localparam int SET_GPIO = 7; // Drive gpio_in from din
  localparam int CHK_TXF  = 8; // Transmit FIFO of mindex full

  logic             clk;
  logic             reset;
  logic [1:0]       mindex;
  logic [4:0]       index;
  pio_pkg::action_e action;
  logic [31:0]      din;
  logic [31:0]      dout;
  logic [31:0]      gpio_in;
  logic [31:0]      gpio_out;
  logic [31:0]      gpio_dir;
  int               cycles = 0;
  int               cycle_limit = 0;

  string            step_name [$];
  pio_pkg::action_e step_act  [$];
  logic [1:0]       step_m    [$];
  logic [4:0]       step_idx  [$];
  logic [31:0]      step_din  [$];
  logic [31:0]      step_exp  [$];
  int               step_kind [$];

  pio pio_i (
    .clk      (clk),
    .reset    (reset),
    .mindex   (mindex),
    .index    (index),
    .action   (action),
    .din      (din),
    .dout     (dout),
    .gpio_in  (gpio_in),
    .gpio_out (gpio_out),
    .gpio_dir (gpio_dir)
  );

  bind pio_fifo pio_assertions fifo_assert_i (
    .clk(clk), .reset(reset), .full(port.full), .empty(port.empty), .push(port.push),
    .wptr(wptr), .state(pio_pkg::ST_OFF), .en(1'b0), .exec(1'b0)
  );

  bind pio_machine pio_assertions machine_assert_i (
    .clk(clk), .reset(reset), .full(1'b0), .empty(1'b0), .push(1'b0),
    .wptr('0), .state(state), .en(en), .exec(exec)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("Timeout, the DUT gave no result within %0d cycles", cycle_limit);
      $display("Regression failed");
      $fatal(1, "Run stopped by the cycle limit");
    end
  end

  function automatic logic [15:0] encode(input pio_pkg::opcode_e op, input logic [4:0] delay,
                                         input logic [2:0] sel, input logic [4:0] data);
    return {op, delay, sel, data};
  endfunction

  task automatic add_step(input string name, input pio_pkg::action_e act, input logic [1:0] m,
                          input logic [4:0] idx, input logic [31:0] data,
                          input logic [31:0] exp, input int kind);
    step_name.push_back(name);
    step_act.push_back(act);
    step_m.push_back(m);
    step_idx.push_back(idx);
    step_din.push_back(data);
    step_exp.push_back(exp);
    step_kind.push_back(kind);
  endtask

  task automatic add_instr(input logic [4:0] idx, input logic [15:0] word);
    add_step("imem", pio_pkg::ACT_INSTR, 2'd0, idx, {16'd0, word}, 32'd0, CHK_NONE);
  endtask

  task automatic add_cmd(input pio_pkg::action_e act, input logic [1:0] m,
                         input logic [31:0] data);
    add_step("cmd", act, m, 5'd0, data, 32'd0, CHK_NONE);
  endtask

  task automatic add_read(input string name, input logic [1:0] m, input logic [31:0] exp);
    add_step(name, pio_pkg::ACT_READ_RX, m, 5'd0, 32'd0, exp, CHK_RX);
  endtask

  task automatic build_table();
    logic [31:0] w [5];
    logic [31:0] g_low;
    logic [31:0] g_high;
    for (int i = 0; i < 5; i++) w[i] = $urandom();
    g_low  = $urandom() & 32'hffff_fffe;  // Pin 0 low, WAIT holds
    g_high = $urandom() | 32'h0000_0001;
    // Reset values; status holds rx empty in 3..0 and tx empty in 11..8
    add_step("reset_dout", pio_pkg::ACT_NOP, 2'd0, 5'd0, 32'd0, 32'd0, CHK_DOUT);
    add_step("reset_gpio_out", pio_pkg::ACT_NOP, 2'd0, 5'd0, 32'd0, 32'd0, CHK_OUT);
    add_step("reset_gpio_dir", pio_pkg::ACT_NOP, 2'd0, 5'd0, 32'd0, 32'd0, CHK_DIR);
    add_step("reset_status", pio_pkg::ACT_STATUS, 2'd0, 5'd0, 32'd0, 32'h0f0f, CHK_DOUT);
    // Echo on machine 0
    add_instr(5'd0, encode(pio_pkg::OP_PULL, 5'd0, 3'd0, 5'd0));
    add_instr(5'd1, encode(pio_pkg::OP_OUT, 5'd0, pio_pkg::X, 5'd0));
    add_instr(5'd2, encode(pio_pkg::OP_IN, 5'd0, pio_pkg::X, 5'd0));
    add_instr(5'd3, encode(pio_pkg::OP_PUSH, 5'd1, 3'd0, 5'd0)); // One delay tick
    add_cmd(pio_pkg::ACT_WRAP, 2'd0, 32'd0 | (32'd3 << 5));
    add_cmd(pio_pkg::ACT_ENABLE, 2'd0, 32'h1);
    add_cmd(pio_pkg::ACT_WRITE_TX, 2'd0, w[0]);
    add_cmd(pio_pkg::ACT_WRITE_TX, 2'd0, w[1]);
    add_read("echo_0", 2'd0, w[0]);
    add_read("echo_1", 2'd0, w[1]);
    add_cmd(pio_pkg::ACT_DIV, 2'd0, 32'd3);
    add_cmd(pio_pkg::ACT_WRITE_TX, 2'd0, w[2]);
    add_cmd(pio_pkg::ACT_WRITE_TX, 2'd0, w[3]);
    add_read("echo_div_0", 2'd0, w[2]);
    add_read("echo_div_1", 2'd0, w[3]);
    // Counting loop on machine 1
    add_instr(5'd4, encode(pio_pkg::OP_SET, 5'd0, pio_pkg::X, 5'd3));
    add_instr(5'd5, encode(pio_pkg::OP_IN, 5'd0, pio_pkg::X, 5'd0));
    add_instr(5'd6, encode(pio_pkg::OP_PUSH, 5'd0, 3'd0, 5'd0));
    add_instr(5'd7, encode(pio_pkg::OP_JMP, 5'd0, pio_pkg::X_DEC, 5'd5));
    add_cmd(pio_pkg::ACT_WRAP, 2'd1, 32'd4 | (32'd7 << 5));
    add_cmd(pio_pkg::ACT_ENABLE, 2'd0, 32'h2);
    add_read("count_3", 2'd1, 32'd3);
    add_read("count_2", 2'd1, 32'd2);
    add_read("count_1", 2'd1, 32'd1);
    add_read("count_0", 2'd1, 32'd0);
    add_read("count_wrap", 2'd1, 32'd3);
    // Set group through exec on machine 2, base 4 and count 4
    add_cmd(pio_pkg::ACT_PINS, 2'd2, (32'd4 << 8) | (32'd4 << 11));
    add_cmd(pio_pkg::ACT_EXEC, 2'd2,
            {16'd0, encode(pio_pkg::OP_SET, 5'd0, pio_pkg::PINDIRS, 5'd15)});
    add_cmd(pio_pkg::ACT_EXEC, 2'd2,
            {16'd0, encode(pio_pkg::OP_SET, 5'd0, pio_pkg::PINS, 5'd5)});
    add_step("exec_dirs", pio_pkg::ACT_NOP, 2'd2, 5'd0, 32'd0, 32'd15 << 4, CHK_DIR);
    add_step("exec_pins", pio_pkg::ACT_NOP, 2'd2, 5'd0, 32'd0, 32'd5 << 4, CHK_OUT);
    // Machine 2 stays off, so the fifth write meets a full FIFO
    for (int i = 0; i < 5; i++) add_cmd(pio_pkg::ACT_WRITE_TX, 2'd2, w[i]);
    add_step("tx_full", pio_pkg::ACT_STATUS, 2'd2, 5'd0, 32'd0, 32'd1, CHK_TXF);
    // WAIT on pin 0, then IN pins with in base 7 on machine 3
    add_step("gpio", pio_pkg::ACT_NOP, 2'd3, 5'd0, g_low, 32'd0, SET_GPIO);
    add_instr(5'd8, encode(pio_pkg::OP_WAIT, 5'd0, 3'b100, 5'd0));
    add_instr(5'd9, encode(pio_pkg::OP_IN, 5'd0, pio_pkg::PINS, 5'd0));
    add_instr(5'd10, encode(pio_pkg::OP_PUSH, 5'd0, 3'd0, 5'd0));
    add_cmd(pio_pkg::ACT_WRAP, 2'd3, 32'd8 | (32'd10 << 5));
    add_cmd(pio_pkg::ACT_PINS, 2'd3, 32'd7 << 16);
    add_cmd(pio_pkg::ACT_ENABLE, 2'd0, 32'h8);
    for (int i = 0; i < 4; i++) add_cmd(pio_pkg::ACT_NOP, 2'd0, 32'd0);
    add_step("wait_holds", pio_pkg::ACT_STATUS, 2'd3, 5'd0, 32'd0, 32'd1, CHK_RXE);
    add_step("gpio", pio_pkg::ACT_NOP, 2'd3, 5'd0, g_high, 32'd0, SET_GPIO);
    add_read("in_pins", 2'd3, (g_high >> 7) | (g_high << 25));
    // OUT pins on machine 0, base 8 and count 4
    add_cmd(pio_pkg::ACT_ENABLE, 2'd0, 32'h0);
    add_instr(5'd12, encode(pio_pkg::OP_PULL, 5'd0, 3'd0, 5'd0));
    add_instr(5'd13, encode(pio_pkg::OP_OUT, 5'd0, pio_pkg::PINS, 5'd4));
    add_cmd(pio_pkg::ACT_DIV, 2'd0, 32'd0);
    add_cmd(pio_pkg::ACT_WRAP, 2'd0, 32'd12 | (32'd13 << 5));
    add_cmd(pio_pkg::ACT_PINS, 2'd0, 32'd4 | (32'd8 << 3));
    add_cmd(pio_pkg::ACT_ENABLE, 2'd0, 32'h1);
    add_cmd(pio_pkg::ACT_WRITE_TX, 2'd0, w[4]);
    add_step("out_pins", pio_pkg::ACT_NOP, 2'd0, 5'd0, 32'd0,
             (32'd5 << 4) | {20'd0, w[4][3:0], 8'd0}, CHK_TXE); // Machine 2 pins stay set
  endtask

  // Drives one command, returns half a step after the edge that takes it
  task automatic host_cmd(input pio_pkg::action_e act, input logic [1:0] m,
                          input logic [4:0] idx, input logic [31:0] data);
    action = act;
    mindex = m;
    index  = idx;
    din    = data;
    @(posedge clk);
    #0.5;
    action = pio_pkg::ACT_NOP;
  endtask

  task automatic wait_rx_data(input logic [1:0] m);
    do begin
      host_cmd(pio_pkg::ACT_STATUS, m, 5'd0, 32'd0);
    end while (dout[m]);
  endtask

  task automatic wait_tx_empty(input logic [1:0] m);
    do begin
      host_cmd(pio_pkg::ACT_STATUS, m, 5'd0, 32'd0);
    end while (!dout[8 + m]);
  endtask

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("Error: %s expected %h actual %h", name, exp, act);
      $display("Regression failed");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  initial begin
    logic [31:0] seed;
    seed = $urandom(32'h14cc_345b);
    build_table();
    cycle_limit = step_act.size() * 64;
    reset   = 1'b1;
    action  = pio_pkg::ACT_NOP;
    mindex  = 2'd0;
    index   = 5'd0;
    din     = 32'd0;
    gpio_in = seed & 32'hffff_fffe;
    repeat (5) @(posedge clk);
    #0.5;
    reset = 1'b0;
    for (int i = 0; i < step_act.size(); i++) begin
      case (step_kind[i])
        CHK_RX: begin
          wait_rx_data(step_m[i]);
          host_cmd(step_act[i], step_m[i], step_idx[i], step_din[i]);
          check(step_name[i], step_exp[i], dout);
        end
        CHK_RXE: begin
          host_cmd(step_act[i], step_m[i], step_idx[i], step_din[i]);
          check(step_name[i], step_exp[i], {31'd0, dout[step_m[i]]});
        end
        CHK_TXF: begin
          host_cmd(step_act[i], step_m[i], step_idx[i], step_din[i]);
          check(step_name[i], step_exp[i], {31'd0, dout[12 + step_m[i]]});
        end
        CHK_TXE: begin
          wait_tx_empty(step_m[i]);
          check(step_name[i], step_exp[i], gpio_out);
        end
        SET_GPIO: begin
          gpio_in = step_din[i];
          host_cmd(pio_pkg::ACT_NOP, 2'd0, 5'd0, 32'd0);
        end
        default: begin
          host_cmd(step_act[i], step_m[i], step_idx[i], step_din[i]);
          if (step_kind[i] == CHK_DOUT) check(step_name[i], step_exp[i], dout);
          if (step_kind[i] == CHK_OUT) check(step_name[i], step_exp[i], gpio_out);
          if (step_kind[i] == CHK_DIR) check(step_name[i], step_exp[i], gpio_dir);
        end
      endcase
    end
    $display("Regression passed");
    $finish;
  end

endmodule

//--- pio.f
+incdir+common
common/pio_pkg.sv
common/pio_fifo_if.sv
hw/pio_fifo.sv
hw/machine/pio_clock_div.sv
hw/machine/pio_machine.sv
hw/pio.sv
sim/pio_assertions.sv
sim/pio_tb.sv

//--- Makefile
# Verilator build and run for the PIO block

VERILATOR ?= verilator
TOP       ?= pio_tb
FILELIST  ?= pio.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Regression passed

SIM = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
